// File: testbench/testdata.txt
// nameFlashAddr _ attrFlashAddr _ nameRamStart _ attrRamStart _ mode
// mode 0 name only, 1 name and attr, 2 attr alone
001200_004000_020_100_0
01F3A0_0A8010_040_120_1
003300_00C0C0_060_140_2
7FFFF0_123456_060_140_1
FFFFF8_00FF00_080_160_0
05A5A5_0C3C3C_1F8_1FE_1
246800_13579B_0A0_180_1
000000_000000_0C0_1A0_2

// File: files.f
design/scrollPkg.sv
design/spiMaster.sv
design/flashToNametable.sv
design/tileRam.sv
design/scrollLoader.sv
testbench/spiFlashModel.sv
testbench/scrollLoader_assertions.sv
testbench/tbScrollLoader.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbScrollLoader
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tbScrollLoader.sv
`timescale 1ns/1ns

module tbScrollLoader
    import scrollPkg::*;
();

    localparam int MAX_LINES = 32;
    localparam int QUIET_CYCLES = 16;
    localparam int BYTE_CYCLES = 16 * SPI_CLK_DIV + 3;
    localparam int LOAD_CYCLES = (8 + NAME_BYTES + ATTR_BYTES) * BYTE_CYCLES + 16;

    typedef struct packed {
        logic [23:0] nameAddr;
        logic [23:0] attrAddr;
        logic [11:0] nameStart;
        logic [11:0] attrStart;
        logic [3:0]  mode;   // 0 name, 1 name and attr, 2 attr alone
    } stimLine_t;

    logic                  clk;
    logic                  rstn;
    logic                  nameReq;
    logic                  attrReq;
    flashAddr_t            nameFlashAddr;
    flashAddr_t            attrFlashAddr;
    logic [RAM_ADDR_W-1:0] nameRamStart;
    logic [RAM_ADDR_W-1:0] attrRamStart;
    logic [RAM_ADDR_W-1:0] nameRdAddr;
    logic [RAM_ADDR_W-1:0] attrRdAddr;
    logic [31:0]           nameRdData;
    logic [31:0]           attrRdData;
    logic                  busy;
    logic                  spiClk;
    logic                  spiCs;
    logic                  spiMosi;
    logic                  spiMiso;

    logic [75:0] stimMem [MAX_LINES];
    logic [31:0] nameExp [2**RAM_ADDR_W];
    logic [31:0] attrExp [2**RAM_ADDR_W];
    bit          nameKnown [2**RAM_ADDR_W];
    bit          attrKnown [2**RAM_ADDR_W];
    int          seed;
    int          lineCount;
    int          errorCount;
    int          checkCount;
    int          assertFails;
    int          cycleCnt = 0;
    int          cycleLimit;

    scrollLoader i_dut (.*);

    spiFlashModel flash (
        .spiClk  (spiClk),
        .spiCs   (spiCs),
        .spiMosi (spiMosi),
        .spiMiso (spiMiso)
    );

    bind flashToNametable scrollLoader_assertions protocolChecks (
        .clk      (clk),
        .rstn     (rstn),
        .spiCmd   (spiCmd),
        .byteDone (byteDone),
        .busy     (busy),
        .state    (state),
        .nameWr   (nameWr),
        .attrWr   (attrWr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("timeout after %0d cycles, busy is %0b", cycleCnt, busy);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] ruleByte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    task automatic checkValue(input string sigName, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, sigName, actual, expected);
        end
    endtask

    // big endian words from consecutive flash bytes
    task automatic recordLoad(input logic [23:0] base, input logic [8:0] start,
                              input int nBytes, input bit toAttr);
        logic [31:0] word;
        logic [8:0]  wa;
        for (int w = 0; w < nBytes / 4; w++) begin
            for (int b = 0; b < 4; b++) begin
                word[31 - 8 * b -: 8] = ruleByte(base + 24'(4 * w + b));
            end
            wa = start + 9'(w);   // wraps like the ram
            if (toAttr) begin
                attrExp[wa] = word;
                attrKnown[wa] = 1'b1;
            end else begin
                nameExp[wa] = word;
                nameKnown[wa] = 1'b1;
            end
        end
    endtask

    task automatic readbackRams();
        for (int a = 0; a < 2**RAM_ADDR_W; a++) begin
            if (nameKnown[a] || attrKnown[a]) begin
                nameRdAddr = RAM_ADDR_W'(a);
                attrRdAddr = RAM_ADDR_W'(a);
                @(negedge clk);
                if (nameKnown[a]) begin
                    checkValue($sformatf("nameRdData[%0d]", a), nameRdData, nameExp[a]);
                end
                if (attrKnown[a]) begin
                    checkValue($sformatf("attrRdData[%0d]", a), attrRdData, attrExp[a]);
                end
            end
        end
    endtask

    task automatic runLoad(input stimLine_t ln);
        int gap;
        int waitCnt;
        gap = ($random(seed) & 31) + 2;
        repeat (gap) @(negedge clk);
        nameFlashAddr.flat = ln.nameAddr;
        attrFlashAddr.flat = ln.attrAddr;
        nameRamStart = ln.nameStart[8:0];
        attrRamStart = ln.attrStart[8:0];
        nameReq = (ln.mode != 4'd2);
        attrReq = (ln.mode != 4'd0);
        if (ln.mode == 4'd2) begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                checkValue("busy", 32'(busy), 32'd0);
                checkValue("spiCs", 32'(spiCs), 32'd1);
            end
        end else begin
            waitCnt = 0;
            while (!busy && waitCnt < QUIET_CYCLES) begin
                @(negedge clk);
                waitCnt++;
            end
            if (!busy) begin
                errorCount++;
                $display("busy did not rise within %0d cycles of a load request", QUIET_CYCLES);
            end else begin
                // second request with other fields while busy
                repeat (40) @(negedge clk);
                nameReq = 1'b0;
                attrReq = 1'b0;
                nameFlashAddr.flat = ~ln.nameAddr;
                attrFlashAddr.flat = ~ln.attrAddr;
                nameRamStart = ln.nameStart[8:0] - 9'h020;
                attrRamStart = ln.attrStart[8:0] - 9'h020;
                repeat (8) @(negedge clk);
                nameReq = 1'b1;
                attrReq = 1'b1;
                while (busy) @(negedge clk);
                checkValue("spiCs", 32'(spiCs), 32'd1);
                @(negedge clk);   // last word lands a cycle after busy falls
                recordLoad(ln.nameAddr, ln.nameStart[8:0], NAME_BYTES, 1'b0);
                if (ln.mode == 4'd1) begin
                    recordLoad(ln.attrAddr, ln.attrStart[8:0], ATTR_BYTES, 1'b1);
                end
            end
        end
        nameReq = 1'b0;
        attrReq = 1'b0;
        readbackRams();
    endtask

    initial begin
        seed = 32'h18ea;
        errorCount = 0;
        checkCount = 0;
        rstn = 1'b0;
        nameReq = 1'b0;
        attrReq = 1'b0;
        nameFlashAddr = '0;
        attrFlashAddr = '0;
        nameRamStart = '0;
        attrRamStart = '0;
        nameRdAddr = '0;
        attrRdAddr = '0;
        for (int i = 0; i < MAX_LINES; i++) begin
            stimMem[i] = '1;   // unread lines stay all ones
        end
        $readmemh("testbench/testdata.txt", stimMem);
        lineCount = 0;
        while (lineCount < MAX_LINES && stimMem[lineCount] !== '1) lineCount++;
        cycleLimit = 2 * (lineCount + 1) * LOAD_CYCLES;

        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        checkValue("busy", 32'(busy), 32'd0);
        checkValue("spiCs", 32'(spiCs), 32'd1);
        checkValue("spiClk", 32'(spiClk), 32'd0);
        if (lineCount == 0) begin
            errorCount++;
            $display("no stimulus lines were read from testbench/testdata.txt");
        end
        for (int i = 0; i < lineCount; i++) begin
            runLoad(stimLine_t'(stimMem[i]));
        end

        assertFails = i_dut.loader.protocolChecks.failCount;
        $display("done: %0d checks, %0d errors, %0d assertion failures",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/scrollLoader_assertions.sv
`timescale 1ns/1ns

module scrollLoader_assertions
    import scrollPkg::*;
(
    input logic       clk,
    input logic       rstn,
    input spiCmd_t    spiCmd,
    input logic       byteDone,
    input logic       busy,
    input logic [2:0] state,
    input ramWrite_t  nameWr,
    input ramWrite_t  attrWr
);

    logic inFlight;   // byte between txReq and byteDone
    int   txReqFails = 0;
    int   csFails = 0;
    int   laneFails = 0;
    int   failCount;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            inFlight <= 1'b0;
        end else if (spiCmd.txReq) begin
            inFlight <= 1'b1;
        end else if (byteDone) begin
            inFlight <= 1'b0;
        end
    end

    assign failCount = txReqFails + csFails + laneFails;

    txReqWhileIdle: assert property (@(posedge clk) disable iff (!rstn)
        spiCmd.txReq |-> !inFlight)
        else begin
            $error("txReq raised while a byte is in flight");
            txReqFails++;
        end

    csLowWhileBusy: assert property (@(posedge clk) disable iff (!rstn)
        (busy && state != ST_GAP) |-> !spiCmd.cs)
        else begin
            $error("spiCs high during a transaction");
            csFails++;
        end

    oneLanePerCycle: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({nameWr.byteEn, attrWr.byteEn}))
        else begin
            $error("more than one byte enable set");
            laneFails++;
        end

endmodule

// File: testbench/spiFlashModel.sv
`timescale 1ns/1ns

module spiFlashModel
    import scrollPkg::*;
(
    input  logic spiClk,
    input  logic spiCs,
    input  logic spiMosi,
    output logic spiMiso
);

    int         bitCnt = 0;   // rising edges since cs fell
    int         dataBit;
    logic [7:0] rxByte = 8'h00;
    logic [7:0] cmdByte = 8'h00;
    logic [7:0] outByte;
    logic       misoBit = 1'b0;
    flashAddr_t addr;

    function automatic logic [7:0] contentByte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // command and address bytes arrive msb first
    always @(posedge spiClk or posedge spiCs) begin
        if (spiCs) begin
            bitCnt = 0;
        end else begin
            rxByte = {rxByte[6:0], spiMosi};
            bitCnt = bitCnt + 1;
            case (bitCnt)
                8:  cmdByte = rxByte;
                16: addr.bytes.hi = rxByte;
                24: addr.bytes.mid = rxByte;
                32: addr.bytes.lo = rxByte;
                default: ;
            endcase
        end
    end

    // data bits change on falling edges once the address is in
    always @(negedge spiClk) begin
        if (!spiCs && bitCnt >= 32 && cmdByte == FLASH_READ_CMD) begin
            dataBit = bitCnt - 32;
            outByte = contentByte(addr.flat + 24'(dataBit / 8));
            misoBit <= outByte[7 - dataBit % 8];
        end
    end

    assign spiMiso = misoBit;

endmodule

// File: design/scrollLoader.sv
`timescale 1ns/1ns

module scrollLoader
    import scrollPkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  nameReq,
    input  logic                  attrReq,
    input  flashAddr_t            nameFlashAddr,
    input  flashAddr_t            attrFlashAddr,
    input  logic [RAM_ADDR_W-1:0] nameRamStart,
    input  logic [RAM_ADDR_W-1:0] attrRamStart,
    input  logic [RAM_ADDR_W-1:0] nameRdAddr,
    output logic [31:0]           nameRdData,
    input  logic [RAM_ADDR_W-1:0] attrRdAddr,
    output logic [31:0]           attrRdData,
    output logic                  busy,
    output logic                  spiClk,
    output logic                  spiCs,
    output logic                  spiMosi,
    input  logic                  spiMiso
);

    spiCmd_t    spiCmd;
    logic [7:0] rxData;
    logic       byteDone;
    ramWrite_t  nameWr;
    ramWrite_t  attrWr;

    flashToNametable loader (
        .clk           (clk),
        .rstn          (rstn),
        .nameReq       (nameReq),
        .attrReq       (attrReq),
        .nameFlashAddr (nameFlashAddr),
        .attrFlashAddr (attrFlashAddr),
        .nameRamStart  (nameRamStart),
        .attrRamStart  (attrRamStart),
        .rxData        (rxData),
        .byteDone      (byteDone),
        .spiCmd        (spiCmd),
        .nameWr        (nameWr),
        .attrWr        (attrWr),
        .busy          (busy)
    );

    spiMaster spi (
        .clk      (clk),
        .rstn     (rstn),
        .cmd      (spiCmd),
        .rxData   (rxData),
        .byteDone (byteDone),
        .spiClk   (spiClk),
        .spiCs    (spiCs),
        .spiMosi  (spiMosi),
        .spiMiso  (spiMiso)
    );

    tileRam nameRam (
        .clk    (clk),
        .wr     (nameWr),
        .rdAddr (nameRdAddr),
        .rdData (nameRdData)
    );

    tileRam attrRam (
        .clk    (clk),
        .wr     (attrWr),
        .rdAddr (attrRdAddr),
        .rdData (attrRdData)
    );

endmodule

// File: design/tileRam.sv
`timescale 1ns/1ns

module tileRam
    import scrollPkg::*;
(
    input  logic                  clk,
    input  ramWrite_t             wr,
    input  logic [RAM_ADDR_W-1:0] rdAddr,
    output logic [31:0]           rdData
);

    logic [31:0] mem [2**RAM_ADDR_W];

    always_ff @(posedge clk) begin
        // lane i covers bits 31-8i down
        for (int i = 0; i < 4; i++) begin
            if (wr.byteEn[i]) begin
                mem[wr.addr][31 - 8 * i -: 8] <= wr.data[31 - 8 * i -: 8];
            end
        end
        rdData <= mem[rdAddr];
    end

endmodule

// File: design/flashToNametable.sv
`timescale 1ns/1ns

module flashToNametable
    import scrollPkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  nameReq,
    input  logic                  attrReq,
    input  flashAddr_t            nameFlashAddr,
    input  flashAddr_t            attrFlashAddr,
    input  logic [RAM_ADDR_W-1:0] nameRamStart,
    input  logic [RAM_ADDR_W-1:0] attrRamStart,
    input  logic [7:0]            rxData,
    input  logic                  byteDone,
    output spiCmd_t               spiCmd,
    output ramWrite_t             nameWr,
    output ramWrite_t             attrWr,
    output logic                  busy
);

    logic [1:0]            reqSync;   // bit 0 name, bit 1 attr
    logic [1:0]            reqDly;
    logic [1:0]            reqTrig;
    logic [2:0]            state;
    logic                  attrPhase;
    logic                  attrPending;
    logic [READ_CNT_W-1:0] readCnt;
    logic [READ_CNT_W-1:0] lastCnt;
    flashAddr_t            nameAddrQ;
    flashAddr_t            attrAddrQ;
    flashAddr_t            curAddr;
    logic [7:0]            nextByte;
    logic                  wrHit;
    logic [3:0]            laneEn;
    logic [3:0]            laneEnQ [2];   // index 0 name, 1 attr
    logic [RAM_ADDR_W-1:0] wrAddrQ [2];
    logic [31:0]           wrDataQ [2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            reqSync <= 2'b00;
            reqDly <= 2'b00;
            reqTrig <= 2'b00;
        end else begin
            reqSync <= {attrReq, nameReq};
            reqDly <= reqSync;
            reqTrig <= reqSync & ~reqDly;
        end
    end

    assign busy = (state != ST_IDLE);
    assign curAddr = attrPhase ? attrAddrQ : nameAddrQ;
    assign lastCnt = attrPhase ? READ_CNT_W'(ATTR_BYTES - 1) : READ_CNT_W'(NAME_BYTES - 1);
    assign wrHit = byteDone && (state == ST_READ);
    assign laneEn = 4'b0001 << readCnt[1:0];

    // byte to send after the one in flight
    always_comb begin
        case (state)
            ST_SEND_CMD: nextByte = curAddr.bytes.hi;
            ST_SEND_HI:  nextByte = curAddr.bytes.mid;
            ST_SEND_MID: nextByte = curAddr.bytes.lo;
            default:     nextByte = DUMMY_BYTE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && reqTrig[0]) begin
            nameAddrQ <= nameFlashAddr;
            attrAddrQ <= attrFlashAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
            attrPhase <= 1'b0;
            attrPending <= 1'b0;
            readCnt <= '0;
            spiCmd <= '{cs: 1'b1, txReq: 1'b0, txData: 8'h00};
        end else begin
            spiCmd.txReq <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (reqTrig[0]) begin
                        state <= ST_SEND_CMD;
                        attrPhase <= 1'b0;
                        attrPending <= reqTrig[1];   // attr alone is dropped
                        spiCmd <= '{cs: 1'b0, txReq: 1'b1, txData: FLASH_READ_CMD};
                    end
                end
                ST_SEND_CMD, ST_SEND_HI, ST_SEND_MID, ST_SEND_LO: begin
                    if (byteDone) begin
                        state <= state + 3'd1;
                        readCnt <= '0;
                        spiCmd.txReq <= 1'b1;
                        spiCmd.txData <= nextByte;
                    end
                end
                ST_READ: begin
                    if (byteDone) begin
                        if (readCnt == lastCnt) begin
                            spiCmd.cs <= 1'b1;
                            readCnt <= '0;
                            state <= (attrPending && !attrPhase) ? ST_GAP : ST_IDLE;
                        end else begin
                            readCnt <= readCnt + 1'b1;
                            spiCmd.txReq <= 1'b1;
                            spiCmd.txData <= nextByte;
                        end
                    end
                end
                ST_GAP: begin
                    state <= ST_SEND_CMD;
                    attrPhase <= 1'b1;
                    spiCmd <= '{cs: 1'b0, txReq: 1'b1, txData: FLASH_READ_CMD};
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2; i++) begin
                laneEnQ[i] <= 4'b0000;
                wrAddrQ[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                laneEnQ[i] <= (wrHit && int'(attrPhase) == i) ? laneEn : 4'b0000;
                if (laneEnQ[i][3]) begin
                    wrAddrQ[i] <= wrAddrQ[i] + 1'b1;   // word complete
                end
            end
            if (state == ST_IDLE && reqTrig[0]) begin
                wrAddrQ[0] <= nameRamStart;
                if (reqTrig[1]) begin
                    wrAddrQ[1] <= attrRamStart;
                end
            end
        end
    end

    // big endian packing, first byte to 31:24
    always_ff @(posedge clk) begin
        if (wrHit) begin
            wrDataQ[attrPhase][31 - 8 * readCnt[1:0] -: 8] <= rxData;
        end
    end

    assign nameWr = '{byteEn: laneEnQ[0], addr: wrAddrQ[0], data: wrDataQ[0]};
    assign attrWr = '{byteEn: laneEnQ[1], addr: wrAddrQ[1], data: wrDataQ[1]};

endmodule

// File: design/spiMaster.sv
`timescale 1ns/1ns

module spiMaster
    import scrollPkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  spiCmd_t    cmd,
    output logic [7:0] rxData,
    output logic       byteDone,
    output logic       spiClk,
    output logic       spiCs,
    output logic       spiMosi,
    input  logic       spiMiso
);

    logic                 active;
    logic [DIV_CNT_W-1:0] divCnt;
    logic [3:0]           halfCnt;   // spi clock edges within the byte
    logic [7:0]           txShift;
    logic [7:0]           rxShift;
    logic                 edgeTick;

    assign edgeTick = active && (divCnt == DIV_CNT_W'(SPI_CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            active <= 1'b0;
            divCnt <= '0;
            halfCnt <= 4'd0;
            spiClk <= 1'b0;
            byteDone <= 1'b0;
            txShift <= 8'h00;
        end else begin
            byteDone <= 1'b0;
            if (cmd.txReq && !active) begin
                active <= 1'b1;
                divCnt <= '0;
                halfCnt <= 4'd0;
                txShift <= cmd.txData;   // bit 7 on mosi right away
            end else if (active) begin
                divCnt <= edgeTick ? '0 : divCnt + 1'b1;
                if (edgeTick) begin
                    spiClk <= ~spiClk;
                    halfCnt <= halfCnt + 4'd1;
                    if (halfCnt[0]) begin
                        txShift <= {txShift[6:0], 1'b0};   // falling edge
                    end
                    // byte ends with clock back low
                    if (halfCnt == 4'd15) begin
                        active <= 1'b0;
                        byteDone <= 1'b1;
                    end
                end
            end
        end
    end

    // sample on rising edges, msb first
    always_ff @(posedge clk) begin
        if (edgeTick && !halfCnt[0]) begin
            rxShift <= {rxShift[6:0], spiMiso};
        end
    end

    assign rxData = rxShift;
    assign spiMosi = txShift[7];
    assign spiCs = cmd.cs;

endmodule

// File: design/scrollPkg.sv
package scrollPkg;

    localparam int SPI_CLK_DIV = 4;          // sys clocks per spi half period
    localparam int DIV_CNT_W = $clog2(SPI_CLK_DIV);

    localparam logic [7:0] FLASH_READ_CMD = 8'h03;
    localparam logic [7:0] DUMMY_BYTE = 8'hFF;

    localparam int NAME_BYTES = 32;
    localparam int ATTR_BYTES = 8;
    localparam int READ_CNT_W = $clog2(NAME_BYTES);

    localparam int RAM_ADDR_W = 9;

    // sequencer states, command and address states are consecutive
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_SEND_CMD = 3'd1;
    localparam logic [2:0] ST_SEND_HI = 3'd2;
    localparam logic [2:0] ST_SEND_MID = 3'd3;
    localparam logic [2:0] ST_SEND_LO = 3'd4;
    localparam logic [2:0] ST_READ = 3'd5;
    localparam logic [2:0] ST_GAP = 3'd6;   // cs high between transactions

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] mid;
        logic [7:0] lo;
    } flashAddrBytes_t;

    typedef union packed {
        logic [23:0]     flat;
        flashAddrBytes_t bytes;   // order on the wire
    } flashAddr_t;

    typedef struct packed {
        logic       cs;
        logic       txReq;
        logic [7:0] txData;
    } spiCmd_t;

    typedef struct packed {
        logic [3:0]            byteEn;   // bit 0 is bits 31:24
        logic [RAM_ADDR_W-1:0] addr;
        logic [31:0]           data;
    } ramWrite_t;

endpackage
